// File: design/issue_pkg.sv
package issue_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int ISSUE_WIDTH      = 3;    // Lanes per group
    localparam int ARCH_REGS        = 32;
    localparam int PHYS_REGS        = 64;
    localparam int FREE_SLOTS       = PHYS_REGS - ARCH_REGS;
    localparam int MAP_READS        = 3 * ISSUE_WIDTH;  // rs1, rs2 and rd per lane
    localparam int DISPATCH_CREDITS = 8;    // Downstream slots after reset
    localparam int CREDIT_W         = 4;

    typedef logic [31:0]                      xlen_t;
    typedef logic [$clog2(ARCH_REGS)-1:0]     arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]     phys_reg_t;
    typedef logic [CREDIT_W-1:0]              credit_t;
    typedef logic [ISSUE_WIDTH-1:0]           lane_mask_t;
    typedef logic [$clog2(FREE_SLOTS)-1:0]    free_idx_t;
    typedef logic [$clog2(FREE_SLOTS+1)-1:0]  free_count_t;

    // ========================================
    // Lane records
    // ========================================
    typedef struct packed {
        logic  valid;
        xlen_t instr;
        xlen_t pc;
        xlen_t imm;
    } fetch_lane_t;

    typedef struct packed {
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      writes_rd;
    } decoded_lane_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     imm;
        phys_reg_t rs1_phys;
        phys_reg_t rs2_phys;
        phys_reg_t rd_phys;
        phys_reg_t old_rd_phys;     // Mapping replaced by rd, freed at commit
        arch_reg_t rd_arch;
    } renamed_lane_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t phys;
    } commit_lane_t;

endpackage

// File: design/rv32i_field_decoder.sv
`timescale 1ns/1ps

module rv32i_field_decoder (
    input  issue_pkg::xlen_t         instr_i,
    output issue_pkg::decoded_lane_t decoded_o
);

    logic [6:0] opcode;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       has_rd;

    assign opcode = instr_i[6:0];

    // Register usage per opcode class
    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        has_rd   = 1'b0;
        case (opcode)
            7'b0110111,                     // LUI
            7'b0010111,                     // AUIPC
            7'b1101111: begin               // JAL
                has_rd = 1'b1;
            end
            7'b1100111,                     // JALR
            7'b0000011,                     // Loads
            7'b0010011: begin               // OP-IMM
                has_rd   = 1'b1;
                uses_rs1 = 1'b1;
            end
            7'b0110011: begin               // OP
                has_rd   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            7'b1100011,                     // Branches
            7'b0100011: begin               // Stores
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: begin
                has_rd = 1'b0;              // FENCE, SYSTEM and unknown touch no register
            end
        endcase
    end

    assign decoded_o.rs1       = uses_rs1 ? instr_i[19:15] : '0;
    assign decoded_o.rs2       = uses_rs2 ? instr_i[24:20] : '0;
    assign decoded_o.rd        = has_rd ? instr_i[11:7] : '0;
    assign decoded_o.writes_rd = has_rd && (instr_i[11:7] != '0);   // x0 is never renamed

endmodule

// File: design/rename_map_table.sv
`timescale 1ns/1ps

module rename_map_table (
    input  logic                  clk,
    input  logic                  reset,
    input  issue_pkg::arch_reg_t  rd_addr_i [issue_pkg::MAP_READS],
    output issue_pkg::phys_reg_t  rd_data_o [issue_pkg::MAP_READS],
    input  issue_pkg::lane_mask_t wr_en_i,
    input  issue_pkg::arch_reg_t  wr_arch_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::phys_reg_t  wr_phys_i [issue_pkg::ISSUE_WIDTH]
);

    issue_pkg::phys_reg_t map_q [issue_pkg::ARCH_REGS];

    // Asynchronous read ports
    always_comb begin
        for (int r = 0; r < issue_pkg::MAP_READS; r++) begin
            rd_data_o[r] = map_q[rd_addr_i[r]];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int a = 0; a < issue_pkg::ARCH_REGS; a++) begin
                map_q[a] <= issue_pkg::phys_reg_t'(a);     // Identity mapping
            end
        end else begin
            // Later lanes are younger, so the last write to an entry must stick
            for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
                if (wr_en_i[l]) begin
                    map_q[wr_arch_i[l]] <= wr_phys_i[l];
                end
            end
        end
    end

endmodule

// File: design/phys_free_list.sv
`timescale 1ns/1ps

module phys_free_list (
    input  logic                   clk,
    input  logic                   reset,
    input  issue_pkg::lane_mask_t  alloc_mask_i,
    output issue_pkg::phys_reg_t   alloc_phys_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::free_count_t free_count_o,
    input  issue_pkg::commit_lane_t release_i   [issue_pkg::ISSUE_WIDTH]
);

    issue_pkg::phys_reg_t   list_q [issue_pkg::FREE_SLOTS];
    issue_pkg::free_idx_t   head_q;
    issue_pkg::free_idx_t   tail_q;
    issue_pkg::free_count_t count_q;

    issue_pkg::free_idx_t   alloc_ptr;                          // Head after this allocation
    issue_pkg::free_idx_t   rel_ptr;                            // Tail after these releases
    issue_pkg::free_idx_t   rel_idx [issue_pkg::ISSUE_WIDTH];
    issue_pkg::lane_mask_t  rel_mask;

    // Marked lanes take consecutive entries from the head
    always_comb begin
        alloc_ptr = head_q;
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            alloc_phys_o[l] = list_q[alloc_ptr];
            if (alloc_mask_i[l]) begin
                alloc_ptr = alloc_ptr + 1'b1;
            end
        end
    end

    // Released registers pack in lane order at the tail
    always_comb begin
        rel_ptr = tail_q;
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            rel_idx[l]  = rel_ptr;
            rel_mask[l] = release_i[l].valid;
            if (release_i[l].valid) begin
                rel_ptr = rel_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < issue_pkg::FREE_SLOTS; i++) begin
                list_q[i] <= issue_pkg::phys_reg_t'(issue_pkg::ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;                                      // Full list wraps tail onto head
            count_q <= issue_pkg::free_count_t'(issue_pkg::FREE_SLOTS);
        end else begin
            for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
                if (release_i[l].valid) begin
                    list_q[rel_idx[l]] <= release_i[l].phys;
                end
            end
            head_q  <= alloc_ptr;
            tail_q  <= rel_ptr;
            count_q <= count_q + issue_pkg::free_count_t'($countones(rel_mask))
                               - issue_pkg::free_count_t'($countones(alloc_mask_i));
        end
    end

    assign free_count_o = count_q;

endmodule

// File: design/rename_unit.sv
`timescale 1ns/1ps

module rename_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush_i,
    input  issue_pkg::fetch_lane_t    fetch_i   [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::decoded_lane_t  decoded_i [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::commit_lane_t   commit_i  [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::credit_t        credits_i,
    output logic                      accept_o,
    output issue_pkg::credit_t        issued_count_o,
    output issue_pkg::renamed_lane_t  renamed_o [issue_pkg::ISSUE_WIDTH]
);

    issue_pkg::lane_mask_t  valid_mask;
    issue_pkg::lane_mask_t  need_mask;                          // Valid lanes writing rd
    issue_pkg::lane_mask_t  alloc_mask;
    issue_pkg::free_count_t free_count;
    issue_pkg::free_count_t need_count;
    issue_pkg::credit_t     valid_count;
    issue_pkg::arch_reg_t   map_addr   [issue_pkg::MAP_READS];
    issue_pkg::phys_reg_t   map_data   [issue_pkg::MAP_READS];
    issue_pkg::arch_reg_t   wr_arch    [issue_pkg::ISSUE_WIDTH];
    issue_pkg::phys_reg_t   alloc_phys [issue_pkg::ISSUE_WIDTH];

    always_comb begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            valid_mask[l]   = fetch_i[l].valid;
            need_mask[l]    = fetch_i[l].valid && decoded_i[l].writes_rd;
            map_addr[3*l]   = decoded_i[l].rs1;
            map_addr[3*l+1] = decoded_i[l].rs2;
            map_addr[3*l+2] = decoded_i[l].rd;
            wr_arch[l]      = decoded_i[l].rd;
        end
    end

    // ========================================
    // Group acceptance
    // ========================================
    assign need_count     = issue_pkg::free_count_t'($countones(need_mask));
    assign valid_count    = issue_pkg::credit_t'($countones(valid_mask));
    assign accept_o       = !flush_i && (free_count >= need_count) && (credits_i >= valid_count);
    assign alloc_mask     = accept_o ? need_mask : '0;
    assign issued_count_o = accept_o ? valid_count : '0;

    rename_map_table map_table_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_i (map_addr),
        .rd_data_o (map_data),
        .wr_en_i   (alloc_mask),
        .wr_arch_i (wr_arch),
        .wr_phys_i (alloc_phys)
    );

    phys_free_list free_list_inst (
        .clk          (clk),
        .reset        (reset),
        .alloc_mask_i (alloc_mask),
        .alloc_phys_o (alloc_phys),
        .free_count_o (free_count),
        .release_i    (commit_i)
    );

    // Table lookup, then bypass from older lanes of the same group
    // x0 needs no case of its own since its entry stays at phys 0
    always_comb begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            renamed_o[l].valid       = fetch_i[l].valid;
            renamed_o[l].pc          = fetch_i[l].pc;
            renamed_o[l].imm         = fetch_i[l].imm;
            renamed_o[l].rd_arch     = decoded_i[l].rd;
            renamed_o[l].rs1_phys    = map_data[3*l];
            renamed_o[l].rs2_phys    = map_data[3*l+1];
            renamed_o[l].old_rd_phys = map_data[3*l+2];
            for (int k = 0; k < l; k++) begin
                if (need_mask[k] && decoded_i[k].rd == decoded_i[l].rs1) begin
                    renamed_o[l].rs1_phys = alloc_phys[k];
                end
                if (need_mask[k] && decoded_i[k].rd == decoded_i[l].rs2) begin
                    renamed_o[l].rs2_phys = alloc_phys[k];
                end
                if (need_mask[k] && decoded_i[k].rd == decoded_i[l].rd) begin
                    renamed_o[l].old_rd_phys = alloc_phys[k];   // Overwritten within group
                end
            end
            renamed_o[l].rd_phys = need_mask[l] ? alloc_phys[l] : '0;
            if (!need_mask[l]) begin
                renamed_o[l].old_rd_phys = '0;
            end
        end
    end

endmodule

// File: design/dispatch_credit_counter.sv
`timescale 1ns/1ps

module dispatch_credit_counter (
    input  logic               clk,
    input  logic               reset,
    input  issue_pkg::credit_t issued_count_i,     // Lanes accepted this edge
    input  issue_pkg::credit_t returned_count_i,   // Slots freed by dispatch
    input  issue_pkg::credit_t restored_count_i,   // Lanes dropped by flush
    output issue_pkg::credit_t credits_o
);

    issue_pkg::credit_t credits_q;

    // Never underflows since acceptance is gated by this count
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            credits_q <= issue_pkg::credit_t'(issue_pkg::DISPATCH_CREDITS);
        end else begin
            credits_q <= credits_q + returned_count_i + restored_count_i - issued_count_i;
        end
    end

    assign credits_o = credits_q;

endmodule

// File: design/issue_output_reg.sv
`timescale 1ns/1ps

module issue_output_reg (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush_i,
    input  logic                     load_i,
    input  issue_pkg::renamed_lane_t lanes_i [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::renamed_lane_t lanes_o [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::credit_t       discarded_count_o
);

    issue_pkg::lane_mask_t    in_valid;
    issue_pkg::lane_mask_t    valid_q;
    issue_pkg::renamed_lane_t data_q [issue_pkg::ISSUE_WIDTH];

    always_comb begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            in_valid[l] = lanes_i[l].valid;
        end
    end

    // Lanes live for a single cycle unless a new group is loaded
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= (load_i && !flush_i) ? in_valid : '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            if (flush_i) begin
                data_q[l] <= '0;
            end else if (load_i) begin
                data_q[l] <= lanes_i[l];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            lanes_o[l]       = data_q[l];
            lanes_o[l].valid = valid_q[l];
        end
    end

    // Credits of the lanes dropped at this edge go back to the counter
    assign discarded_count_o = flush_i ? issue_pkg::credit_t'($countones(valid_q)) : '0;

endmodule

// File: design/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush_i,
    input  issue_pkg::fetch_lane_t   fetch_i    [issue_pkg::ISSUE_WIDTH],
    output logic                     group_ready_o,
    input  issue_pkg::credit_t       credit_return_i,
    input  issue_pkg::commit_lane_t  commit_i   [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::renamed_lane_t dispatch_o [issue_pkg::ISSUE_WIDTH]
);

    issue_pkg::decoded_lane_t decoded [issue_pkg::ISSUE_WIDTH];
    issue_pkg::renamed_lane_t renamed [issue_pkg::ISSUE_WIDTH];
    issue_pkg::credit_t       credits;
    issue_pkg::credit_t       issued_count;
    issue_pkg::credit_t       discarded_count;

    // ========================================
    // Per-lane field decode
    // ========================================
    for (genvar g = 0; g < issue_pkg::ISSUE_WIDTH; g++) begin : g_decode
        rv32i_field_decoder decoder_inst (
            .instr_i   (fetch_i[g].instr),
            .decoded_o (decoded[g])
        );
    end

    rename_unit rename_inst (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .fetch_i        (fetch_i),
        .decoded_i      (decoded),
        .commit_i       (commit_i),
        .credits_i      (credits),
        .accept_o       (group_ready_o),    // Ready and accept are the same condition
        .issued_count_o (issued_count),
        .renamed_o      (renamed)
    );

    dispatch_credit_counter credit_inst (
        .clk              (clk),
        .reset            (reset),
        .issued_count_i   (issued_count),
        .returned_count_i (credit_return_i),
        .restored_count_i (discarded_count),
        .credits_o        (credits)
    );

    issue_output_reg output_inst (
        .clk               (clk),
        .reset             (reset),
        .flush_i           (flush_i),
        .load_i            (group_ready_o),
        .lanes_i           (renamed),
        .lanes_o           (dispatch_o),
        .discarded_count_o (discarded_count)
    );

endmodule

// File: verification/issue_stage_chk.sv
`timescale 1ns/1ps

module issue_stage_chk (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush_i,
    input  logic                     group_ready_o,
    input  issue_pkg::fetch_lane_t   fetch_i    [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::renamed_lane_t dispatch_o [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::credit_t       credits
);

    issue_pkg::lane_mask_t in_valid;
    issue_pkg::lane_mask_t out_valid;

    always_comb begin
        for (int l = 0; l < issue_pkg::ISSUE_WIDTH; l++) begin
            in_valid[l]  = fetch_i[l].valid;
            out_valid[l] = dispatch_o[l].valid;
        end
    end

    // Flush empties the output register at its edge
    flush_clears: assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> (out_valid == '0))
        else $error("Output lanes still valid the cycle after flush");

    // An accepted group shows up for exactly the next cycle
    group_shows: assert property (@(posedge clk) disable iff (!reset)
        group_ready_o |=> (out_valid == $past(in_valid)))
        else $error("Accepted group lanes not valid on the next cycle");

    idle_clears: assert property (@(posedge clk) disable iff (!reset)
        !group_ready_o |=> (out_valid == '0))
        else $error("Output lanes valid without an accepted group");

    credit_bound: assert property (@(posedge clk) disable iff (!reset)
        credits <= issue_pkg::credit_t'(issue_pkg::DISPATCH_CREDITS))
        else $error("Credit count above the downstream depth");

endmodule

// File: verification/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

    localparam int W          = issue_pkg::ISSUE_WIDTH;
    localparam int RESET_LEN  = 4;
    localparam int RANDOM_LEN = 300;
    localparam int CREDIT_LEN = 80;
    localparam int FREE_LEN   = 120;
    localparam int FLUSH_LEN  = 140;
    localparam int RUN_LIMIT  = 2 * (2 * RESET_LEN + RANDOM_LEN + CREDIT_LEN + FREE_LEN + FLUSH_LEN);

    logic                     clk;
    logic                     reset;
    logic                     flush_i;
    issue_pkg::fetch_lane_t   fetch_i    [W];
    logic                     group_ready_o;
    issue_pkg::credit_t       credit_return_i;
    issue_pkg::commit_lane_t  commit_i   [W];
    issue_pkg::renamed_lane_t dispatch_o [W];

    // Reference model
    issue_pkg::phys_reg_t map_m [issue_pkg::ARCH_REGS];
    bit                   live  [issue_pkg::PHYS_REGS];
    issue_pkg::phys_reg_t free_q [$];                       // Free list in hand-out order
    issue_pkg::phys_reg_t commit_q [$];                     // Old rd regs waiting for commit
    issue_pkg::arch_reg_t g_rs1 [W];
    issue_pkg::arch_reg_t g_rs2 [W];
    issue_pkg::arch_reg_t g_rd  [W];
    bit                   g_wr  [W];

    logic [31:0] seed = 32'hecfc;
    int          cycle;
    int          errors;
    int          test_mark;
    int          tests;
    int          groups;
    int          outstanding;                               // Issued lanes whose credit is out
    int          ret_sched [3];
    int          ret_due;
    int          drv_restore;
    bit          drv_acc;
    bit          fetch_on;
    bit          hold_ret;
    bit          hold_commit;
    int          flush_pct;
    int          credit_stalls;
    int          free_stalls;
    int          flushed_lanes;

    issue_stage issue_stage_inst (
        .clk             (clk),
        .reset           (reset),
        .flush_i         (flush_i),
        .fetch_i         (fetch_i),
        .group_ready_o   (group_ready_o),
        .credit_return_i (credit_return_i),
        .commit_i        (commit_i),
        .dispatch_o      (dispatch_o)
    );

    bind issue_stage issue_stage_chk chk_inst (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .group_ready_o (group_ready_o),
        .fetch_i       (fetch_i),
        .dispatch_o    (dispatch_o),
        .credits       (credits)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        errors++;
    endtask

    // One random RV32I instruction per lane, with the fields it really uses
    task automatic drive_group();
        logic [31:0]          r;
        int                   cls;
        issue_pkg::arch_reg_t rd;
        issue_pkg::arch_reg_t rs1;
        issue_pkg::arch_reg_t rs2;
        for (int l = 0; l < W; l++) begin
            r   = xorshift();
            cls = int'(r[10:8]) % 6;
            rd  = r[5] ? {2'b00, r[2:0]} : r[15:11];        // Narrow range gives in-group hazards
            rs1 = r[6] ? {2'b00, r[18:16]} : r[20:16];
            rs2 = r[7] ? {2'b00, r[23:21]} : r[25:21];
            fetch_i[l].valid = fetch_on && (r[27:26] != 2'b00);
            fetch_i[l].pc    = 32'h1000 + 32'(cycle * 12 + l * 4);
            fetch_i[l].imm   = {20'h0, r[31:20]};
            g_rd[l]  = rd;
            g_rs1[l] = rs1;
            g_rs2[l] = rs2;
            case (cls)
                0: fetch_i[l].instr = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};   // OP
                1: begin
                    fetch_i[l].instr = {r[31:20], rs1, 3'b000, rd, 7'b0010011};    // OP-IMM
                    g_rs2[l] = '0;
                end
                2: begin
                    fetch_i[l].instr = {r[31:12], rd, 7'b0110111};                 // LUI
                    g_rs1[l] = '0;
                    g_rs2[l] = '0;
                end
                3: begin
                    fetch_i[l].instr = {7'h00, rs2, rs1, 3'b010, 5'b00000, 7'b0100011};
                    g_rd[l] = '0;
                end
                4: begin
                    fetch_i[l].instr = {7'h00, rs2, rs1, 3'b000, 5'b00000, 7'b1100011};
                    g_rd[l] = '0;
                end
                default: begin
                    fetch_i[l].instr = {12'h000, rs1, 3'b000, rd, 7'b1100111};     // JALR
                    g_rs2[l] = '0;
                end
            endcase
            g_wr[l] = fetch_i[l].valid && (g_rd[l] != '0);
        end
    endtask

    // ========================================
    // One cycle: check, update model, drive
    // ========================================
    task automatic step();
        int                   n_vis;
        int                   n_valid;
        int                   n_need;
        int                   give;
        int                   d;
        logic [31:0]          r;
        bit                   exp_ready;
        issue_pkg::phys_reg_t exp_rd;
        issue_pkg::phys_reg_t exp_old;
        n_vis = 0;
        for (int l = 0; l < W; l++) begin
            n_vis += dispatch_o[l].valid ? 1 : 0;           // Lanes dispatch actually receives
            if (!(drv_acc && fetch_i[l].valid)) begin
                assert (!dispatch_o[l].valid)
                    else report_mismatch($sformatf("lane %0d valid without accepted group", l));
            end else begin
                exp_rd  = '0;
                exp_old = '0;
                if (g_wr[l]) begin
                    exp_rd  = (free_q.size() > 0) ? free_q.pop_front() : '0;
                    exp_old = map_m[g_rd[l]];
                end
                assert (dispatch_o[l].valid && dispatch_o[l].pc == fetch_i[l].pc
                        && dispatch_o[l].imm == fetch_i[l].imm
                        && dispatch_o[l].rd_arch == g_rd[l])
                    else report_mismatch($sformatf("lane %0d payload or rd arch differs", l));
                assert (dispatch_o[l].rs1_phys == map_m[g_rs1[l]])
                    else report_mismatch($sformatf("lane %0d rs1 phys %0d, expected %0d", l,
                                         dispatch_o[l].rs1_phys, map_m[g_rs1[l]]));
                assert (dispatch_o[l].rs2_phys == map_m[g_rs2[l]])
                    else report_mismatch($sformatf("lane %0d rs2 phys %0d, expected %0d", l,
                                         dispatch_o[l].rs2_phys, map_m[g_rs2[l]]));
                assert (dispatch_o[l].rd_phys == exp_rd && dispatch_o[l].old_rd_phys == exp_old)
                    else report_mismatch($sformatf("lane %0d rd %0d old %0d, expected %0d old %0d",
                                         l, dispatch_o[l].rd_phys, dispatch_o[l].old_rd_phys,
                                         exp_rd, exp_old));
                if (g_wr[l]) begin
                    assert (dispatch_o[l].rd_phys != '0 && !live[dispatch_o[l].rd_phys])
                        else report_mismatch($sformatf("lane %0d new rd phys %0d is zero or live",
                                             l, dispatch_o[l].rd_phys));
                    live[exp_rd]   = 1'b1;
                    map_m[g_rd[l]] = exp_rd;                // Later lanes see this mapping
                    commit_q.push_back(exp_old);
                end
            end
        end
        groups += (n_vis > 0) ? 1 : 0;
        outstanding += n_vis - int'(credit_return_i) - drv_restore;
        assert (outstanding >= 0 && outstanding <= issue_pkg::DISPATCH_CREDITS)
            else report_mismatch($sformatf("%0d lanes outstanding", outstanding));
        for (int l = 0; l < W; l++) begin
            if (commit_i[l].valid) begin
                free_q.push_back(commit_i[l].phys);         // Appended after this edge's allocation
                live[commit_i[l].phys] = 1'b0;
            end
        end

        // Dispatch side: flush or schedule credit returns
        r = xorshift();
        flush_i     = (int'(r[3:0]) < flush_pct);
        drv_restore = flush_i ? n_vis : 0;
        flushed_lanes += drv_restore;
        ret_due += ret_sched[0];
        ret_sched[0] = ret_sched[1];
        ret_sched[1] = ret_sched[2];
        ret_sched[2] = 0;
        for (int l = 0; l < n_vis; l++) begin
            d = int'(r[4 + 2 * l +: 2]) % 3;                // One to three cycles later
            if (!flush_i) begin
                ret_sched[d]++;
            end
        end
        give = hold_ret ? 0 : ((ret_due > 3) ? 3 : ret_due);
        ret_due -= give;
        credit_return_i = issue_pkg::credit_t'(give);

        for (int l = 0; l < W; l++) begin
            commit_i[l] = '0;
            if (!hold_commit && r[12 + l] && commit_q.size() > 0) begin
                commit_i[l].valid = 1'b1;
                commit_i[l].phys  = commit_q.pop_front();
            end
        end

        drive_group();
        n_valid = 0;
        n_need  = 0;
        for (int l = 0; l < W; l++) begin
            n_valid += fetch_i[l].valid ? 1 : 0;
            n_need  += g_wr[l] ? 1 : 0;
        end
        #1;
        exp_ready = !flush_i && (free_q.size() >= n_need)
                    && (issue_pkg::DISPATCH_CREDITS - outstanding >= n_valid);
        assert (group_ready_o == exp_ready)
            else report_mismatch($sformatf("group_ready_o %0b, expected %0b (free %0d, out %0d)",
                                 group_ready_o, exp_ready, free_q.size(), outstanding));
        if (!group_ready_o && !flush_i) begin
            free_stalls   += (free_q.size() < n_need) ? 1 : 0;
            credit_stalls += (issue_pkg::DISPATCH_CREDITS - outstanding < n_valid) ? 1 : 0;
        end
        drv_acc = exp_ready;
        @(negedge clk);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %-16s done, %0d errors", name, errors - test_mark);
        test_mark = errors;
    endtask

    initial begin
        cycle = 0;
        while (cycle < RUN_LIMIT) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: run still going after %0d cycles", RUN_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int mark;
        reset           = 1'b0;
        flush_i         = 1'b0;
        credit_return_i = '0;
        for (int l = 0; l < W; l++) begin
            fetch_i[l]  = '0;
            commit_i[l] = '0;
        end
        for (int a = 0; a < issue_pkg::ARCH_REGS; a++) begin
            map_m[a] = issue_pkg::phys_reg_t'(a);
        end
        for (int p = 0; p < issue_pkg::PHYS_REGS; p++) begin
            live[p] = (p < issue_pkg::ARCH_REGS);
            if (p >= issue_pkg::ARCH_REGS) begin
                free_q.push_back(issue_pkg::phys_reg_t'(p));
            end
        end
        repeat (RESET_LEN) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // ========================================
        // Tests
        // ========================================
        for (int l = 0; l < W; l++) begin
            assert (!dispatch_o[l].valid)
                else report_mismatch($sformatf("lane %0d valid after reset", l));
        end
        assert (group_ready_o) else report_mismatch("group_ready_o low after reset");
        run_cycles(RESET_LEN);
        finish_test("reset");

        fetch_on = 1'b1;
        run_cycles(RANDOM_LEN);
        finish_test("random rename");

        hold_ret      = 1'b1;
        credit_stalls = 0;
        run_cycles(CREDIT_LEN / 2);
        if (credit_stalls == 0) begin
            report_failure("stage never stalled with dispatch credits held back");
        end
        hold_ret = 1'b0;
        mark     = groups;
        run_cycles(CREDIT_LEN / 2);
        if (groups == mark) begin
            report_failure("stage did not resume after credits were returned");
        end
        finish_test("credit stall");

        hold_commit = 1'b1;
        free_stalls = 0;
        run_cycles(FREE_LEN / 2);
        if (free_stalls == 0) begin
            report_failure("stage never stalled with commits held back");
        end
        hold_commit = 1'b0;
        mark        = groups;
        run_cycles(FREE_LEN / 2);
        if (groups == mark) begin
            report_failure("stage did not resume after registers were freed");
        end
        finish_test("free list stall");

        flush_pct = 2;                                      // About one flush in eight cycles
        run_cycles(FLUSH_LEN - 40);
        flush_pct = 0;
        fetch_on  = 1'b0;
        run_cycles(20);
        if (flushed_lanes == 0) begin
            report_failure("no lane was ever discarded by a flush");
        end

        // With every return in, the stage must fill the whole downstream depth again
        hold_ret = 1'b1;
        fetch_on = 1'b1;
        run_cycles(20);
        if (outstanding < issue_pkg::DISPATCH_CREDITS - W + 1) begin
            report_failure("stage could not issue the full credit depth after flushes");
        end
        finish_test("flush");

        $display("Tests run: %0d, groups checked: %0d, errors: %0d", tests, groups, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
design/issue_pkg.sv
design/rv32i_field_decoder.sv
design/rename_map_table.sv
design/phys_free_list.sv
design/rename_unit.sv
design/dispatch_credit_counter.sv
design/issue_output_reg.sv
design/issue_stage.sv
verification/issue_stage_chk.sv
verification/issue_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module issue_stage_tb -f flist.f -o issue_stage_sim \
    && ./obj_dir/issue_stage_sim > sim.log 2>&1 \
    || echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -q "TEST PASSED" sim.log && ! grep -q "TEST FAILED" sim.log
